//--- compile.f
rtl/sw_alloc_pkg.sv
rtl/vc_arbiter.sv
rtl/output_arbiter.sv
rtl/credit_tracker.sv
rtl/alloc_feedback.sv
rtl/lookahead_sw_alloc.sv
verification/sw_alloc_properties.sv
verification/tb_lookahead_sw_alloc.sv

//--- rtl/alloc_feedback.sv
`timescale 1ns/1ns
`default_nettype none

module alloc_feedback (
    input  sw_alloc_pkg::port_vec_t [sw_alloc_pkg::NUM_PORT-1:0] win_req,
    input  sw_alloc_pkg::vc_idx_t   [sw_alloc_pkg::NUM_PORT-1:0] sel_vc,
    input  sw_alloc_pkg::pc_idx_t   [sw_alloc_pkg::NUM_PORT-1:0] sel_pc,
    output sw_alloc_pkg::port_vec_t [sw_alloc_pkg::NUM_PORT-1:0] uppv,
    output logic [sw_alloc_pkg::NUM_NET_PORT-1:0]                grant_new
);

    import sw_alloc_pkg::*;

    ////////////////////
    // retry vector

    // requested but lost, so the input keeps asking for it
    always_comb begin
        for (int i = 0; i < NUM_PORT; i++) begin
            for (int o = 0; o < NUM_PORT; o++) begin
                uppv[i][o] = win_req[i][o] && (sel_pc[o] != pc_idx_t'(i));
            end
        end
    end

    ////////////////////
    // bypass grant

    for (genvar i = 0; i < NUM_NET_PORT; i++) begin : g_bypass
        // outputs won by this input
        port_vec_t won_at;

        for (genvar o = 0; o < NUM_PORT; o++) begin : g_won
            assign won_at[o] = (sel_pc[o] == pc_idx_t'(i));
        end

        // newest flit sits in the bypass VC
        assign grant_new[i] = (sel_vc[i] == vc_idx_t'(BYPASS_VC)) && |won_at;
    end

endmodule

`default_nettype wire

//--- rtl/credit_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module credit_tracker (
    input  logic                     clk,
    input  logic                     arst_n,
    input  sw_alloc_pkg::ds_vc_vec_t consume,
    input  sw_alloc_pkg::ds_vc_vec_t credit_return_in,
    output sw_alloc_pkg::ds_vc_vec_t credit_avail
);

    import sw_alloc_pkg::*;

    // free slots per downstream VC
    credit_t [NUM_DS_VC-1:0] count;

    ////////////////////
    // counter update

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int v = 0; v < NUM_DS_VC; v++) begin
                count[v] <= credit_t'(BUFFER_DEPTH);
            end
        end else begin
            for (int v = 0; v < NUM_DS_VC; v++) begin
                // return and consume together cancel out
                if (credit_return_in[v] && !consume[v]) begin
                    count[v] <= count[v] + 1'b1;
                end else if (consume[v] && !credit_return_in[v]) begin
                    count[v] <= count[v] - 1'b1;
                end
            end
        end
    end

    // registered view, so a consume shows up next cycle
    always_comb begin
        for (int v = 0; v < NUM_DS_VC; v++) begin
            credit_avail[v] = (count[v] != '0);
        end
    end

endmodule

`default_nettype wire

//--- rtl/lookahead_sw_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module lookahead_sw_alloc (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  sw_alloc_pkg::port_vec_t
               [sw_alloc_pkg::NUM_PORT-1:0][sw_alloc_pkg::NUM_VC-1:0] req,
    input  sw_alloc_pkg::age_t
               [sw_alloc_pkg::NUM_PORT-1:0][sw_alloc_pkg::NUM_VC-1:0] age,
    input  sw_alloc_pkg::ds_vc_vec_t [sw_alloc_pkg::NUM_NET_PORT-1:0] credit_return_in,
    output sw_alloc_pkg::vc_idx_t    [sw_alloc_pkg::NUM_PORT-1:0]     sel_vc,
    output sw_alloc_pkg::pc_idx_t    [sw_alloc_pkg::NUM_PORT-1:0]     sel_pc,
    output sw_alloc_pkg::ds_vc_idx_t [sw_alloc_pkg::NUM_PORT-1:0]     vc_new,
    output sw_alloc_pkg::ds_vc_vec_t [sw_alloc_pkg::NUM_NET_PORT-1:0] credit_return_out,
    output sw_alloc_pkg::port_vec_t  [sw_alloc_pkg::NUM_PORT-1:0]     uppv,
    output logic [sw_alloc_pkg::NUM_NET_PORT-1:0]                     grant_new
);

    import sw_alloc_pkg::*;

    // winner of each input port
    age_t      [NUM_PORT-1:0] win_age;
    port_vec_t [NUM_PORT-1:0] win_req;

    // win_req turned around, one vector per output
    port_vec_t [NUM_PORT-1:0] req_at_out;

    ds_vc_vec_t [NUM_NET_PORT-1:0] credit_avail;

    ////////////////////
    // VC selection

    for (genvar i = 0; i < NUM_PORT; i++) begin : g_in
        vc_arbiter #(
            .NUM_VC_IN (NUM_VC)
        ) u_vc_arb (
            .req     (req[i]),
            .age     (age[i]),
            .sel_vc  (sel_vc[i]),
            .win_age (win_age[i]),
            .win_req (win_req[i])
        );

        for (genvar o = 0; o < NUM_PORT; o++) begin : g_turn
            assign req_at_out[o][i] = win_req[i][o];
        end
    end

    ////////////////////
    // switch arbitration

    for (genvar o = 0; o < NUM_PORT; o++) begin : g_out
        if (o != LOCAL_PORT) begin : g_net
            output_arbiter #(
                .OUT_PORT     (o),
                .CREDIT_CHECK (1'b1)
            ) u_out_arb (
                .win_req_bit  (req_at_out[o]),
                .win_age      (win_age),
                .credit_avail (credit_avail[o]),
                .sel_pc       (sel_pc[o]),
                .vc_new       (vc_new[o]),
                .consume      (credit_return_out[o])
            );

            // downstream slots of this output
            credit_tracker u_credit (
                .clk              (clk),
                .arst_n           (arst_n),
                .consume          (credit_return_out[o]),
                .credit_return_in (credit_return_in[o]),
                .credit_avail     (credit_avail[o])
            );
        end else begin : g_local
            // ejection, always room
            output_arbiter #(
                .OUT_PORT     (o),
                .CREDIT_CHECK (1'b0)
            ) u_out_arb (
                .win_req_bit  (req_at_out[o]),
                .win_age      (win_age),
                .credit_avail ('1),
                .sel_pc       (sel_pc[o]),
                .vc_new       (vc_new[o]),
                .consume      ()
            );
        end
    end

    ////////////////////
    // retry and bypass

    alloc_feedback u_feedback (
        .win_req   (win_req),
        .sel_vc    (sel_vc),
        .sel_pc    (sel_pc),
        .uppv      (uppv),
        .grant_new (grant_new)
    );

endmodule

`default_nettype wire

//--- rtl/output_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module output_arbiter #(
    parameter int OUT_PORT     = 0,
    // ejection port has unlimited buffering
    parameter bit CREDIT_CHECK = (OUT_PORT != sw_alloc_pkg::LOCAL_PORT)
) (
    input  sw_alloc_pkg::port_vec_t                         win_req_bit,
    input  sw_alloc_pkg::age_t [sw_alloc_pkg::NUM_PORT-1:0] win_age,
    input  sw_alloc_pkg::ds_vc_vec_t                        credit_avail,
    output sw_alloc_pkg::pc_idx_t                           sel_pc,
    output sw_alloc_pkg::ds_vc_idx_t                        vc_new,
    output sw_alloc_pkg::ds_vc_vec_t                        consume
);

    import sw_alloc_pkg::*;

    pc_idx_t    best_pc;
    age_t       best_age;
    logic       have_req;
    ds_vc_idx_t vc_pick;
    logic       have_credit;
    logic       granted;

    ////////////////////
    // oldest input wins

    always_comb begin
        best_pc  = '0;
        best_age = '0;
        have_req = 1'b0;
        for (int i = 0; i < NUM_PORT; i++) begin
            // lower index kept on equal age
            if (win_req_bit[i] && (!have_req || win_age[i] > best_age)) begin
                have_req = 1'b1;
                best_pc  = pc_idx_t'(i);
                best_age = win_age[i];
            end
        end
    end

    ////////////////////
    // downstream VC choice

    if (CREDIT_CHECK) begin : g_credit
        // lowest downstream VC with a free slot
        always_comb begin
            vc_pick = '0;
            for (int v = NUM_DS_VC - 1; v >= 0; v--) begin
                if (credit_avail[v]) begin
                    vc_pick = ds_vc_idx_t'(v);
                end
            end
        end
        assign have_credit = |credit_avail;
    end else begin : g_no_credit
        assign vc_pick     = '0;
        assign have_credit = 1'b1;
    end

    // no credit anywhere stalls the whole output
    assign granted = have_req && have_credit;
    assign sel_pc  = granted ? best_pc : NULL_PC;
    assign vc_new  = vc_pick;

    // one slot taken on the chosen VC
    always_comb begin
        consume = '0;
        if (granted) begin
            consume[vc_pick] = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/sw_alloc_pkg.sv
`default_nettype none

package sw_alloc_pkg;

    ////////////////////
    // router geometry

    localparam int NUM_PORT     = 5;
    localparam int NUM_VC       = 6;
    localparam int BYPASS_VC    = 4;
    localparam int NUM_DS_VC    = NUM_VC - 2;
    localparam int NUM_NET_PORT = 4;
    localparam int LOCAL_PORT   = 4;

    // age stamps and downstream buffering
    localparam int TIME_WIDTH   = 8;
    localparam int BUFFER_DEPTH = 4;

    ////////////////////
    // packed types

    // one bit per output port
    typedef logic [NUM_PORT-1:0] port_vec_t;

    // port index, one extra code for "no grant"
    typedef logic [$clog2(NUM_PORT+1)-1:0] pc_idx_t;
    localparam pc_idx_t NULL_PC = pc_idx_t'(NUM_PORT);

    typedef logic [$clog2(NUM_VC)-1:0] vc_idx_t;
    typedef logic [$clog2(NUM_DS_VC)-1:0] ds_vc_idx_t;
    typedef logic [NUM_DS_VC-1:0] ds_vc_vec_t;

    // larger value is the older flit
    typedef logic [TIME_WIDTH-1:0] age_t;

    // holds 0 up to a full buffer
    typedef logic [$clog2(BUFFER_DEPTH+1)-1:0] credit_t;

endpackage

`default_nettype wire

//--- rtl/vc_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module vc_arbiter #(
    parameter int NUM_VC_IN = 6
) (
    input  sw_alloc_pkg::port_vec_t [NUM_VC_IN-1:0] req,
    input  sw_alloc_pkg::age_t      [NUM_VC_IN-1:0] age,
    output sw_alloc_pkg::vc_idx_t                   sel_vc,
    output sw_alloc_pkg::age_t                      win_age,
    output sw_alloc_pkg::port_vec_t                 win_req
);

    import sw_alloc_pkg::*;

    // per-VC request valid, any output wanted
    logic [NUM_VC_IN-1:0] vc_active;

    always_comb begin
        for (int v = 0; v < NUM_VC_IN; v++) begin
            vc_active[v] = |req[v];
        end
    end

    ////////////////////
    // oldest requesting VC

    // strict compare keeps the lowest index on a tie
    always_comb begin : pick_oldest
        logic found;
        found   = 1'b0;
        sel_vc  = '0;
        win_age = '0;
        win_req = '0;
        for (int v = 0; v < NUM_VC_IN; v++) begin
            if (vc_active[v] && (!found || age[v] > win_age)) begin
                found   = 1'b1;
                sel_vc  = vc_idx_t'(v);
                win_age = age[v];
                win_req = req[v];
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/sw_alloc_properties.sv
`timescale 1ns/1ns
`default_nettype none

module sw_alloc_properties (
    input logic                                                 clk,
    input logic                                                 arst_n,
    input sw_alloc_pkg::port_vec_t
              [sw_alloc_pkg::NUM_PORT-1:0][sw_alloc_pkg::NUM_VC-1:0] req,
    input sw_alloc_pkg::age_t
              [sw_alloc_pkg::NUM_PORT-1:0][sw_alloc_pkg::NUM_VC-1:0] age,
    input sw_alloc_pkg::vc_idx_t   [sw_alloc_pkg::NUM_PORT-1:0]     sel_vc,
    input sw_alloc_pkg::pc_idx_t   [sw_alloc_pkg::NUM_PORT-1:0]     sel_pc,
    input sw_alloc_pkg::port_vec_t [sw_alloc_pkg::NUM_PORT-1:0]     uppv,
    input logic [sw_alloc_pkg::NUM_NET_PORT-1:0]                    grant_new
);

    import sw_alloc_pkg::*;

    // number of failed checks so far
    int unsigned fail_count = 0;

    // winning request and age of each input, taken through sel_vc
    port_vec_t [NUM_PORT-1:0]     win_req;
    age_t      [NUM_PORT-1:0]     win_age;
    logic      [NUM_PORT-1:0]     vc_ok;
    logic      [NUM_PORT-1:0]     out_ok;
    port_vec_t [NUM_PORT-1:0]     exp_uppv;
    logic      [NUM_NET_PORT-1:0] exp_grant_new;

    ////////////////////
    // reference of the allocation rules

    always_comb begin : rule_ref
        logic any_req;
        int   w;
        w = 0;
        for (int i = 0; i < NUM_PORT; i++) begin
            any_req    = 1'b0;
            vc_ok[i]   = 1'b1;
            win_req[i] = '0;
            win_age[i] = '0;
            if (sel_vc[i] < NUM_VC) begin
                win_req[i] = req[i][sel_vc[i]];
                win_age[i] = age[i][sel_vc[i]];
            end
            for (int v = 0; v < NUM_VC; v++) begin
                if (req[i][v] != '0) begin
                    any_req = 1'b1;
                    if (age[i][v] > win_age[i] ||
                        (age[i][v] == win_age[i] && v < sel_vc[i])) begin
                        vc_ok[i] = 1'b0;
                    end
                end
            end
            if (any_req && win_req[i] == '0) begin
                vc_ok[i] = 1'b0;
            end
        end
        for (int o = 0; o < NUM_PORT; o++) begin
            out_ok[o] = 1'b1;
            if (sel_pc[o] == NULL_PC) begin
                // ejection has no credit, so a requester always wins it
                if (o == LOCAL_PORT) begin
                    for (int i = 0; i < NUM_PORT; i++) begin
                        if (win_req[i][o]) begin
                            out_ok[o] = 1'b0;
                        end
                    end
                end
            end else if (sel_pc[o] > NULL_PC) begin
                out_ok[o] = 1'b0;
            end else begin
                w = int'(sel_pc[o]);
                if (!win_req[w][o]) begin
                    out_ok[o] = 1'b0;
                end
                for (int i = 0; i < NUM_PORT; i++) begin
                    if (i != w && win_req[i][o] && (win_age[i] > win_age[w] ||
                        (win_age[i] == win_age[w] && i < w))) begin
                        out_ok[o] = 1'b0;
                    end
                end
            end
        end
        for (int i = 0; i < NUM_PORT; i++) begin
            for (int o = 0; o < NUM_PORT; o++) begin
                exp_uppv[i][o] = win_req[i][o] && (sel_pc[o] != pc_idx_t'(i));
            end
        end
        for (int i = 0; i < NUM_NET_PORT; i++) begin
            exp_grant_new[i] = 1'b0;
            for (int o = 0; o < NUM_PORT; o++) begin
                if (sel_vc[i] == vc_idx_t'(BYPASS_VC) && sel_pc[o] == pc_idx_t'(i)) begin
                    exp_grant_new[i] = 1'b1;
                end
            end
        end
    end

    ////////////////////
    // assertions

    a_vc_select: assert property (@(posedge clk) disable iff (!arst_n) &vc_ok)
        else begin
            fail_count++;
            $error("input VC choice is not the oldest requester");
        end

    a_out_select: assert property (@(posedge clk) disable iff (!arst_n) &out_ok)
        else begin
            fail_count++;
            $error("output grant is not the oldest requesting input");
        end

    a_retry: assert property (@(posedge clk) disable iff (!arst_n) uppv == exp_uppv)
        else begin
            fail_count++;
            $error("retry vector does not match lost requests");
        end

    a_bypass: assert property (@(posedge clk) disable iff (!arst_n)
                               grant_new == exp_grant_new)
        else begin
            fail_count++;
            $error("bypass grant does not match the bypass VC winners");
        end

endmodule

bind lookahead_sw_alloc sw_alloc_properties u_props (.*);

`default_nettype wire

//--- verification/tb_lookahead_sw_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lookahead_sw_alloc;

    import sw_alloc_pkg::*;

    localparam int STARVE_TIMEOUT = 100;
    localparam int REFILL_TIMEOUT = 200;

    logic                                  clk;
    logic                                  arst_n;
    port_vec_t  [NUM_PORT-1:0][NUM_VC-1:0] req;
    age_t       [NUM_PORT-1:0][NUM_VC-1:0] age;
    ds_vc_vec_t [NUM_NET_PORT-1:0]         credit_return_in;
    vc_idx_t    [NUM_PORT-1:0]             sel_vc;
    pc_idx_t    [NUM_PORT-1:0]             sel_pc;
    ds_vc_idx_t [NUM_PORT-1:0]             vc_new;
    ds_vc_vec_t [NUM_NET_PORT-1:0]         credit_return_out;
    port_vec_t  [NUM_PORT-1:0]             uppv;
    logic       [NUM_NET_PORT-1:0]         grant_new;

    // expected free slots per network output and downstream VC
    int          model [NUM_NET_PORT][NUM_DS_VC];
    logic [31:0] lfsr;
    logic        check_en;
    logic        phase_done;

    lookahead_sw_alloc DUT (
        .clk               (clk),
        .arst_n            (arst_n),
        .req               (req),
        .age               (age),
        .credit_return_in  (credit_return_in),
        .sel_vc            (sel_vc),
        .sel_pc            (sel_pc),
        .vc_new            (vc_new),
        .credit_return_out (credit_return_out),
        .uppv              (uppv),
        .grant_new         (grant_new)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////
    // helpers

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at %0t ns", $time);
    endtask

    task automatic check_failed(input string msg);
        abort_run($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
    endtask

    // galois LFSR stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic credits_all(input int o, input int value);
        logic same;
        same = 1'b1;
        for (int v = 0; v < NUM_DS_VC; v++) begin
            if (model[o][v] != value) begin
                same = 1'b0;
            end
        end
        return same;
    endfunction

    task automatic drive_stimulus(
        input logic                    dense,
        input int                      age_bits,
        input port_vec_t               force_mask,
        input port_vec_t               clear_mask,
        input logic [NUM_NET_PORT-1:0] ret_en
    );
        logic active;
        for (int i = 0; i < NUM_PORT; i++) begin
            for (int v = 0; v < NUM_VC; v++) begin
                active    = dense ? (take_bits(2) != 0) : (take_bits(2) == 0);
                req[i][v] = '0;
                if (active) begin
                    req[i][v] = (port_vec_t'(take_bits(NUM_PORT)) | force_mask) & ~clear_mask;
                end
                age[i][v] = age_t'(take_bits(age_bits));
            end
        end
        // returns only where a slot is in use
        for (int o = 0; o < NUM_NET_PORT; o++) begin
            for (int v = 0; v < NUM_DS_VC; v++) begin
                credit_return_in[o][v] = ret_en[o] && (model[o][v] < BUFFER_DEPTH) &&
                                         (take_bits(1) != 0);
            end
        end
    endtask

    task automatic run_cycles(
        input int                      n,
        input logic                    dense,
        input int                      age_bits,
        input port_vec_t               force_mask,
        input port_vec_t               clear_mask,
        input logic [NUM_NET_PORT-1:0] ret_en
    );
        for (int c = 0; c < n; c++) begin
            @(posedge clk);
            #1;
            drive_stimulus(dense, age_bits, force_mask, clear_mask, ret_en);
        end
    endtask

    ////////////////////
    // credit model and checks

    task automatic check_credit();
        int   exp_vc;
        logic requested;
        for (int o = 0; o < NUM_NET_PORT; o++) begin
            exp_vc    = -1;
            requested = 1'b0;
            for (int v = NUM_DS_VC - 1; v >= 0; v--) begin
                if (model[o][v] != 0) begin
                    exp_vc = v;
                end
            end
            // requests seen through each input's winning VC
            for (int i = 0; i < NUM_PORT; i++) begin
                if (sel_vc[i] < NUM_VC && req[i][sel_vc[i]][o]) begin
                    requested = 1'b1;
                end
            end
            if (sel_pc[o] != NULL_PC) begin
                assert (credit_return_out[o] == ds_vc_vec_t'(1 << vc_new[o]))
                    else check_failed($sformatf("output %0d credit_return_out %b, vc_new %0d",
                                                o, credit_return_out[o], vc_new[o]));
            end else begin
                assert (credit_return_out[o] == '0)
                    else check_failed($sformatf("output %0d returns credit without a grant", o));
            end
            if (exp_vc < 0) begin
                assert (sel_pc[o] == NULL_PC)
                    else check_failed($sformatf("output %0d granted with no credit", o));
            end else begin
                assert (vc_new[o] == ds_vc_idx_t'(exp_vc))
                    else check_failed($sformatf("output %0d vc_new %0d, expected %0d",
                                                o, vc_new[o], exp_vc));
                assert (!requested || sel_pc[o] != NULL_PC)
                    else check_failed($sformatf("output %0d has credit and %s",
                                                o, "a requester but no grant"));
            end
        end
        // ejection output always uses downstream VC 0
        assert (vc_new[LOCAL_PORT] == '0)
            else check_failed($sformatf("local vc_new is %0d, expected 0",
                                        vc_new[LOCAL_PORT]));
    endtask

    always @(negedge clk) begin
        if (check_en) begin
            if (DUT.u_props.fail_count != 0) begin
                abort_run("an allocation assertion on the DUT failed");
            end
            check_credit();
            for (int o = 0; o < NUM_NET_PORT; o++) begin
                for (int v = 0; v < NUM_DS_VC; v++) begin
                    model[o][v] = model[o][v] - int'(credit_return_out[o][v]) +
                                  int'(credit_return_in[o][v]);
                end
            end
        end
    end

    ////////////////////
    // test sequence

    initial begin
        lfsr             = 32'h30f1_cd83;
        check_en         = 1'b0;
        phase_done       = 1'b0;
        arst_n           = 1'b0;
        req              = '0;
        age              = '0;
        credit_return_in = '0;
        for (int o = 0; o < NUM_NET_PORT; o++) begin
            for (int v = 0; v < NUM_DS_VC; v++) begin
                model[o][v] = BUFFER_DEPTH;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n   = 1'b1;
        check_en = 1'b1;

        // idle outputs straight after reset
        @(negedge clk);
        for (int o = 0; o < NUM_PORT; o++) begin
            assert (sel_pc[o] == NULL_PC)
                else check_failed($sformatf("sel_pc[%0d] is %0d after reset", o, sel_pc[o]));
        end
        assert (credit_return_out == '0 && uppv == '0 && grant_new == '0)
            else check_failed("credit_return_out, uppv or grant_new set after reset");

        run_cycles(200, 1'b0, TIME_WIDTH, '0, '0, '1);
        // narrow ages for many ties
        run_cycles(300, 1'b1, 2, '0, '0, '1);

        // output 0 requested every cycle without returns
        for (int c = 0; c < STARVE_TIMEOUT && !phase_done; c++) begin
            @(posedge clk);
            #1;
            if (credits_all(0, 0)) begin
                phase_done = 1'b1;
            end else begin
                drive_stimulus(1'b1, 2, 5'b00001, '0, 4'b1110);
            end
        end
        if (!phase_done) begin
            abort_run("timeout while waiting for output 0 to run out of credit");
        end
        run_cycles(20, 1'b1, 2, 5'b00001, '0, 4'b1110);

        // refill output 0 with its requests held off
        phase_done = 1'b0;
        for (int c = 0; c < REFILL_TIMEOUT && !phase_done; c++) begin
            @(posedge clk);
            #1;
            if (credits_all(0, BUFFER_DEPTH)) begin
                phase_done = 1'b1;
            end else begin
                drive_stimulus(1'b1, TIME_WIDTH, '0, 5'b00001, '1);
            end
        end
        if (!phase_done) begin
            abort_run("timeout while waiting for output 0 credit to refill");
        end
        run_cycles(50, 1'b0, TIME_WIDTH, '0, '0, '1);

        @(posedge clk);
        #1;
        req              = '0;
        credit_return_in = '0;
        repeat (2) @(negedge clk);
        if (DUT.u_props.fail_count != 0) begin
            abort_run("an allocation assertion on the DUT failed");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
